// File: rtl/openflow_pkg.sv
`default_nettype none

package openflow_pkg;

   // Packet word on the ingress and egress streams
   localparam int DATA_W = 64;
   typedef logic [DATA_W-1:0] data_word_t;

   // Exact-match key taken from the first word of each packet
   typedef logic [DATA_W-1:0] match_key_t;

   // Destination mask, one bit per possible port
   localparam int MAX_PORTS = 8;
   typedef logic [MAX_PORTS-1:0] port_mask_t;

   // Action word layout
   //   [15]   drop flag
   //   [14:8] reserved, zero
   //   [7:0]  destination port mask
   localparam int ACTION_W = 16;
   typedef logic [ACTION_W-1:0] action_t;

   localparam int ACT_DROP_BIT = 15;

endpackage

`default_nettype wire

// File: rtl/host_regs_pkg.sv
`default_nettype none

package host_regs_pkg;

   localparam int REG_ADDR_W = 8;
   localparam int REG_DATA_W = 32;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [REG_DATA_W-1:0] reg_data_t;

   // Staged flow entry
   localparam reg_addr_t REG_KEY_LO    = 8'h00;
   localparam reg_addr_t REG_KEY_HI    = 8'h04;
   localparam reg_addr_t REG_ACTION    = 8'h08;
   // Commit command, index in the low byte
   localparam reg_addr_t REG_ENTRY_CMD = 8'h0C;
   localparam int        CMD_VALID_BIT = 31;

   // Counters
   localparam reg_addr_t REG_HIT_CNT       = 8'h10;
   localparam reg_addr_t REG_MISS_CNT      = 8'h14;
   localparam reg_addr_t REG_FWD_CNT_BASE  = 8'h20;
   localparam reg_addr_t REG_DROP_CNT_BASE = 8'h40;
   localparam int        REG_CNT_STRIDE    = 4;

endpackage

`default_nettype wire

// File: rtl/pkt_preprocessor.sv
`default_nettype none

module pkt_preprocessor import openflow_pkg::*; #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic       asclk,
   input  logic       rst_n,
   input  data_word_t s_tdata,
   input  logic       s_tlast,
   input  logic       s_tvalid,
   output logic       s_tready,
   output logic       lu_req,
   output match_key_t lu_key,
   input  logic       lu_done,
   output data_word_t buf_data,
   output logic       buf_last,
   output logic       buf_valid,
   input  logic       buf_pop
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // Word storage, tlast kept next to each word
   data_word_t       mem_data [FIFO_DEPTH];
   logic             mem_last [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             sop;
   logic             key_pend;
   logic             pkt_out;
   logic             push;

   // New packet waits while the previous key is still being looked up
   assign s_tready  = (count != CNT_W'(FIFO_DEPTH)) && !(sop && key_pend);
   assign push      = s_tvalid && s_tready;
   assign buf_valid = (count != '0);
   assign buf_data  = mem_data[rd_ptr];
   assign buf_last  = mem_last[rd_ptr];

   // Request only once the egress stage has finished the packet ahead
   assign lu_req = key_pend && !pkt_out;

   always_ff @(posedge asclk) begin
      if (push) begin
         mem_data[wr_ptr] <= s_tdata;
         mem_last[wr_ptr] <= s_tlast;
      end
      if (push && sop) begin
         lu_key <= s_tdata;
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         sop      <= 1'b1;
         key_pend <= 1'b0;
         pkt_out  <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            sop    <= s_tlast;
         end
         if (buf_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, buf_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (push && sop) begin
            key_pend <= 1'b1;
         end else if (lu_done) begin
            key_pend <= 1'b0;
         end
         // Packet owns the egress stage from its result to its last word
         if (lu_done) begin
            pkt_out <= 1'b1;
         end else if (buf_pop && buf_last) begin
            pkt_out <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/action_processor.sv
`default_nettype none

module action_processor import openflow_pkg::*, host_regs_pkg::*; (
   input  logic       asclk,
   input  logic       rst_n,
   input  logic       lu_done,
   input  logic       lu_hit,
   input  action_t    lu_action,
   input  data_word_t buf_data,
   input  logic       buf_last,
   input  logic       buf_valid,
   output logic       buf_pop,
   output data_word_t m_tdata,
   output logic       m_tlast,
   output port_mask_t m_tuser,
   output logic       m_tvalid,
   input  logic       m_tready,
   output reg_data_t  fwd_count,
   output reg_data_t  drop_count
);

   // Action held for the packet at the head of the buffer
   logic       active;
   logic       fwd;
   port_mask_t dst_mask;

   // Head word goes straight out, so it holds until popped
   assign m_tdata  = buf_data;
   assign m_tlast  = buf_last;
   assign m_tuser  = dst_mask;
   assign m_tvalid = active && fwd && buf_valid;

   // Miss or drop drains one word per cycle with no egress beat
   assign buf_pop = active && buf_valid && (!fwd || m_tready);

   always_ff @(posedge asclk) begin
      if (lu_done) begin
         dst_mask <= lu_action[MAX_PORTS-1:0];
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         active     <= 1'b0;
         fwd        <= 1'b0;
         fwd_count  <= '0;
         drop_count <= '0;
      end else begin
         if (lu_done) begin
            active <= 1'b1;
            fwd    <= lu_hit && !lu_action[ACT_DROP_BIT];
         end else if (buf_pop && buf_last) begin
            active <= 1'b0;
         end
         // One count per packet, on its last word
         if (buf_pop && buf_last) begin
            if (fwd) begin
               fwd_count <= fwd_count + 1'b1;
            end else begin
               drop_count <= drop_count + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/flow_tbl_ctrl.sv
`default_nettype none

module flow_tbl_ctrl import openflow_pkg::*, host_regs_pkg::*; #(
   parameter int NUM_PORTS = 2,
   parameter int TBL_DEPTH = 8,
   localparam int IDX_W    = $clog2(TBL_DEPTH)
) (
   input  logic                         asclk,
   input  logic                         rst_n,
   input  logic       [NUM_PORTS-1:0]   lu_req,
   input  match_key_t [NUM_PORTS-1:0]   lu_key,
   output logic       [NUM_PORTS-1:0]   lu_done,
   output logic                         lu_hit,
   output action_t                      lu_action,
   input  logic                         entry_wr,
   input  logic       [IDX_W-1:0]       entry_index,
   input  logic                         entry_valid,
   input  match_key_t                   entry_key,
   input  action_t                      entry_action,
   output reg_data_t                    hit_count,
   output reg_data_t                    miss_count
);

   localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   logic [TBL_DEPTH-1:0] tbl_valid;
   match_key_t           tbl_key    [TBL_DEPTH];
   action_t              tbl_action [TBL_DEPTH];

   logic [PORT_W-1:0]    rr_ptr;
   logic                 gnt_vld;
   logic [PORT_W-1:0]    gnt_port;
   logic [NUM_PORTS-1:0] busy;
   logic                 pick_vld;
   logic [PORT_W-1:0]    pick_port;
   logic                 cmp_hit;
   action_t              cmp_action;

   // Round-robin pick, skipping ports already in the pipeline
   always_comb begin
      int idx;
      busy = lu_done;
      if (gnt_vld) begin
         busy[gnt_port] = 1'b1;
      end
      pick_vld  = 1'b0;
      pick_port = '0;
      for (int k = 0; k < NUM_PORTS; k++) begin
         idx = int'(rr_ptr) + k;
         if (idx >= NUM_PORTS) begin
            idx = idx - NUM_PORTS;
         end
         if (!pick_vld && lu_req[idx] && !busy[idx]) begin
            pick_vld  = 1'b1;
            pick_port = PORT_W'(idx);
         end
      end
   end

   // Parallel compare, lowest matching index wins
   always_comb begin
      cmp_hit    = 1'b0;
      cmp_action = '0;
      for (int e = TBL_DEPTH - 1; e >= 0; e--) begin
         if (tbl_valid[e] && (tbl_key[e] == lu_key[gnt_port])) begin
            cmp_hit    = 1'b1;
            cmp_action = tbl_action[e];
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (entry_wr) begin
         tbl_key[entry_index]    <= entry_key;
         tbl_action[entry_index] <= entry_action;
      end
      lu_hit    <= cmp_hit;
      lu_action <= cmp_action;
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         tbl_valid  <= '0;
         rr_ptr     <= '0;
         gnt_vld    <= 1'b0;
         gnt_port   <= '0;
         lu_done    <= '0;
         hit_count  <= '0;
         miss_count <= '0;
      end else begin
         if (entry_wr) begin
            tbl_valid[entry_index] <= entry_valid;
         end
         gnt_vld <= pick_vld;
         if (pick_vld) begin
            gnt_port <= pick_port;
            rr_ptr   <= (pick_port == PORT_W'(NUM_PORTS - 1)) ? '0 : pick_port + 1'b1;
         end
         lu_done <= '0;
         if (gnt_vld) begin
            lu_done[gnt_port] <= 1'b1;
            if (cmp_hit) begin
               hit_count <= hit_count + 1'b1;
            end else begin
               miss_count <= miss_count + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/host_inf.sv
`default_nettype none

module host_inf import openflow_pkg::*, host_regs_pkg::*; #(
   parameter int NUM_PORTS = 2,
   parameter int TBL_DEPTH = 8,
   localparam int IDX_W    = $clog2(TBL_DEPTH)
) (
   input  logic                        asclk,
   input  logic                        rst_n,
   input  logic                        reg_wr,
   input  logic                        reg_rd,
   input  reg_addr_t                   reg_addr,
   input  reg_data_t                   reg_wr_data,
   output reg_data_t                   reg_rd_data,
   output logic                        reg_rd_valid,
   output logic                        entry_wr,
   output logic      [IDX_W-1:0]       entry_index,
   output logic                        entry_valid,
   output match_key_t                  entry_key,
   output action_t                     entry_action,
   input  reg_data_t                   hit_count,
   input  reg_data_t                   miss_count,
   input  reg_data_t [NUM_PORTS-1:0]   fwd_count,
   input  reg_data_t [NUM_PORTS-1:0]   drop_count
);

   reg_data_t key_lo;
   reg_data_t key_hi;
   action_t   act_stage;
   reg_data_t rd_mux;

   assign entry_key    = {key_hi, key_lo};
   assign entry_action = act_stage;

   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         REG_KEY_LO:   rd_mux = key_lo;
         REG_KEY_HI:   rd_mux = key_hi;
         REG_ACTION:   rd_mux = reg_data_t'(act_stage);
         REG_HIT_CNT:  rd_mux = hit_count;
         REG_MISS_CNT: rd_mux = miss_count;
         default:      rd_mux = '0;
      endcase
      // Per-port counter windows
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (reg_addr == REG_FWD_CNT_BASE + reg_addr_t'(REG_CNT_STRIDE * p)) begin
            rd_mux = fwd_count[p];
         end
         if (reg_addr == REG_DROP_CNT_BASE + reg_addr_t'(REG_CNT_STRIDE * p)) begin
            rd_mux = drop_count[p];
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (reg_rd) begin
         reg_rd_data <= rd_mux;
      end
   end

   always_ff @(posedge asclk or negedge rst_n) begin
      if (!rst_n) begin
         key_lo       <= '0;
         key_hi       <= '0;
         act_stage    <= '0;
         entry_wr     <= 1'b0;
         entry_index  <= '0;
         entry_valid  <= 1'b0;
         reg_rd_valid <= 1'b0;
      end else begin
         reg_rd_valid <= reg_rd;
         entry_wr     <= reg_wr && (reg_addr == REG_ENTRY_CMD);
         if (reg_wr) begin
            case (reg_addr)
               REG_KEY_LO: key_lo    <= reg_wr_data;
               REG_KEY_HI: key_hi    <= reg_wr_data;
               REG_ACTION: act_stage <= reg_wr_data[$bits(action_t)-1:0];
               REG_ENTRY_CMD: begin
                  entry_index <= reg_wr_data[IDX_W-1:0];
                  entry_valid <= reg_wr_data[CMD_VALID_BIT];
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/openflow_datapath.sv
`default_nettype none

module openflow_datapath import openflow_pkg::*, host_regs_pkg::*; #(
   parameter int NUM_PORTS  = 2,
   parameter int TBL_DEPTH  = 8,
   parameter int FIFO_DEPTH = 16
) (
   input  logic                         asclk,
   input  logic                         rst_n,
   input  data_word_t [NUM_PORTS-1:0]   s_tdata,
   input  logic       [NUM_PORTS-1:0]   s_tlast,
   input  logic       [NUM_PORTS-1:0]   s_tvalid,
   output logic       [NUM_PORTS-1:0]   s_tready,
   output data_word_t [NUM_PORTS-1:0]   m_tdata,
   output logic       [NUM_PORTS-1:0]   m_tlast,
   output port_mask_t [NUM_PORTS-1:0]   m_tuser,
   output logic       [NUM_PORTS-1:0]   m_tvalid,
   input  logic       [NUM_PORTS-1:0]   m_tready,
   input  logic                         reg_wr,
   input  logic                         reg_rd,
   input  reg_addr_t                    reg_addr,
   input  reg_data_t                    reg_wr_data,
   output reg_data_t                    reg_rd_data,
   output logic                         reg_rd_valid
);

   localparam int IDX_W = $clog2(TBL_DEPTH);

   // Lookup path
   logic       [NUM_PORTS-1:0] lu_req;
   match_key_t [NUM_PORTS-1:0] lu_key;
   logic       [NUM_PORTS-1:0] lu_done;
   logic                       lu_hit;
   action_t                    lu_action;

   // Ingress buffer to egress stage
   data_word_t [NUM_PORTS-1:0] buf_data;
   logic       [NUM_PORTS-1:0] buf_last;
   logic       [NUM_PORTS-1:0] buf_valid;
   logic       [NUM_PORTS-1:0] buf_pop;

   // Host side
   reg_data_t  [NUM_PORTS-1:0] fwd_count;
   reg_data_t  [NUM_PORTS-1:0] drop_count;
   reg_data_t                  hit_count;
   reg_data_t                  miss_count;
   logic                       entry_wr;
   logic       [IDX_W-1:0]     entry_index;
   logic                       entry_valid;
   match_key_t                 entry_key;
   action_t                    entry_action;

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
      pkt_preprocessor #(
         .FIFO_DEPTH(FIFO_DEPTH)
      ) pkt_preprocessor_inst (
         .asclk(asclk),          .rst_n(rst_n),
         .s_tdata(s_tdata[i]),   .s_tlast(s_tlast[i]),
         .s_tvalid(s_tvalid[i]), .s_tready(s_tready[i]),
         .lu_req(lu_req[i]),     .lu_key(lu_key[i]),     .lu_done(lu_done[i]),
         .buf_data(buf_data[i]), .buf_last(buf_last[i]),
         .buf_valid(buf_valid[i]), .buf_pop(buf_pop[i])
      );

      action_processor action_processor_inst (
         .asclk(asclk),          .rst_n(rst_n),
         .lu_done(lu_done[i]),   .lu_hit(lu_hit),        .lu_action(lu_action),
         .buf_data(buf_data[i]), .buf_last(buf_last[i]),
         .buf_valid(buf_valid[i]), .buf_pop(buf_pop[i]),
         .m_tdata(m_tdata[i]),   .m_tlast(m_tlast[i]),   .m_tuser(m_tuser[i]),
         .m_tvalid(m_tvalid[i]), .m_tready(m_tready[i]),
         .fwd_count(fwd_count[i]), .drop_count(drop_count[i])
      );
   end

   flow_tbl_ctrl #(
      .NUM_PORTS(NUM_PORTS),
      .TBL_DEPTH(TBL_DEPTH)
   ) flow_tbl_ctrl_inst (
      .asclk(asclk),             .rst_n(rst_n),
      .lu_req(lu_req),           .lu_key(lu_key),       .lu_done(lu_done),
      .lu_hit(lu_hit),           .lu_action(lu_action),
      .entry_wr(entry_wr),       .entry_index(entry_index),
      .entry_valid(entry_valid), .entry_key(entry_key), .entry_action(entry_action),
      .hit_count(hit_count),     .miss_count(miss_count)
   );

   host_inf #(
      .NUM_PORTS(NUM_PORTS),
      .TBL_DEPTH(TBL_DEPTH)
   ) host_inf_inst (
      .asclk(asclk),             .rst_n(rst_n),
      .reg_wr(reg_wr),           .reg_rd(reg_rd),
      .reg_addr(reg_addr),       .reg_wr_data(reg_wr_data),
      .reg_rd_data(reg_rd_data), .reg_rd_valid(reg_rd_valid),
      .entry_wr(entry_wr),       .entry_index(entry_index),
      .entry_valid(entry_valid), .entry_key(entry_key), .entry_action(entry_action),
      .hit_count(hit_count),     .miss_count(miss_count),
      .fwd_count(fwd_count),     .drop_count(drop_count)
   );

endmodule

`default_nettype wire

// File: verification/openflow_datapath_asserts.sv
`default_nettype none

module openflow_datapath_asserts import openflow_pkg::*; #(
   parameter int NUM_PORTS = 2
) (
   input logic                       asclk,
   input logic                       rst_n,
   input data_word_t [NUM_PORTS-1:0] m_tdata,
   input logic       [NUM_PORTS-1:0] m_tlast,
   input logic       [NUM_PORTS-1:0] m_tvalid,
   input logic       [NUM_PORTS-1:0] m_tready,
   input logic       [NUM_PORTS-1:0] lu_req,
   input logic       [NUM_PORTS-1:0] lu_done,
   input logic                       reg_rd,
   input logic                       reg_rd_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
      // Stalled egress beat stays put
      hold_until_ready: assert property (
         @(posedge asclk) disable iff (!rst_n)
         m_tvalid[i] && !m_tready[i] |=>
            m_tvalid[i] && $stable(m_tdata[i]) && $stable(m_tlast[i])
      ) else $error("port %0d egress beat changed while stalled", i);
   end

   // One lookup result per cycle, only to a port still requesting
   done_onehot: assert property (
      @(posedge asclk) disable iff (!rst_n)
      $onehot0(lu_done) && ((lu_done & ~lu_req) == '0)
   ) else $error("lu_done not one-hot or sent to a port without a request");

   read_reply: assert property (
      @(posedge asclk) disable iff (!rst_n) reg_rd |=> reg_rd_valid
   ) else $error("register read without reply one cycle later");

   read_no_stray: assert property (
      @(posedge asclk) disable iff (!rst_n) !reg_rd |=> !reg_rd_valid
   ) else $error("reg_rd_valid without a read one cycle before");

endmodule

bind openflow_datapath openflow_datapath_asserts #(
   .NUM_PORTS(NUM_PORTS)
) asserts_inst (
   .asclk(asclk),
   .rst_n(rst_n),
   .m_tdata(m_tdata),
   .m_tlast(m_tlast),
   .m_tvalid(m_tvalid),
   .m_tready(m_tready),
   .lu_req(lu_req),
   .lu_done(lu_done),
   .reg_rd(reg_rd),
   .reg_rd_valid(reg_rd_valid)
);

`default_nettype wire

// File: verification/openflow_datapath_tb.sv
`default_nettype none

module openflow_datapath_tb import openflow_pkg::*, host_regs_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_PORTS = 2;
   localparam int TBL_DEPTH = 8;
   localparam int TIMEOUT   = 200;

   localparam match_key_t KEY_A = 64'h0123_4567_89ab_cdef;
   localparam match_key_t KEY_B = 64'hfeed_0000_beef_0001;
   localparam match_key_t KEY_C = 64'h5555_aaaa_0f0f_f0f0;

   logic                       asclk;
   logic                       rst_n;
   data_word_t [NUM_PORTS-1:0] s_tdata;
   logic       [NUM_PORTS-1:0] s_tlast;
   logic       [NUM_PORTS-1:0] s_tvalid;
   logic       [NUM_PORTS-1:0] s_tready;
   data_word_t [NUM_PORTS-1:0] m_tdata;
   logic       [NUM_PORTS-1:0] m_tlast;
   port_mask_t [NUM_PORTS-1:0] m_tuser;
   logic       [NUM_PORTS-1:0] m_tvalid;
   logic       [NUM_PORTS-1:0] m_tready;
   logic                       reg_wr;
   logic                       reg_rd;
   reg_addr_t                  reg_addr;
   reg_data_t                  reg_wr_data;
   reg_data_t                  reg_rd_data;
   logic                       reg_rd_valid;

   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   string       test_name;
   logic [15:0] payload_lfsr;
   logic [15:0] ready_lfsr;
   logic        ready_rand;

   // Counter model, updated from the expected outcome of each packet
   reg_data_t exp_hit;
   reg_data_t exp_miss;
   reg_data_t exp_fwd  [NUM_PORTS];
   reg_data_t exp_drop [NUM_PORTS];

   // Words sent per port, also the expected egress words
   data_word_t stim_data [NUM_PORTS][$];
   logic       stim_last [NUM_PORTS][$];

   openflow_datapath #(
      .NUM_PORTS(NUM_PORTS),
      .TBL_DEPTH(TBL_DEPTH),
      .FIFO_DEPTH(16)
   ) openflow_datapath_inst (
      .asclk(asclk),         .rst_n(rst_n),
      .s_tdata(s_tdata),     .s_tlast(s_tlast),
      .s_tvalid(s_tvalid),   .s_tready(s_tready),
      .m_tdata(m_tdata),     .m_tlast(m_tlast),     .m_tuser(m_tuser),
      .m_tvalid(m_tvalid),   .m_tready(m_tready),
      .reg_wr(reg_wr),       .reg_rd(reg_rd),
      .reg_addr(reg_addr),   .reg_wr_data(reg_wr_data),
      .reg_rd_data(reg_rd_data), .reg_rd_valid(reg_rd_valid)
   );

   always #2 asclk = ~asclk;

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_step(inout logic [15:0] state);
      logic fb;
      fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
      state = {state[14:0], fb};
      return fb;
   endfunction

   // Egress back-pressure, random only during the contention test
   initial begin
      m_tready   = '1;
      ready_lfsr = 16'd59;
      forever begin
         @(posedge asclk);
         #1;
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (ready_rand) begin
               m_tready[p] = lfsr_step(ready_lfsr);
            end else begin
               m_tready[p] = 1'b1;
            end
         end
      end
   end

   task automatic report_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected,
               actual);
      errors++;
   endtask

   task automatic report_error(input string msg);
      $display("ERROR %s: %s", test_name, msg);
      errors++;
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_at_start) begin
         $display("Test %s passed", test_name);
      end else begin
         tests_failed++;
         $display("Test %s failed with %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      @(posedge asclk);
      #1;
      reg_wr      = 1'b1;
      reg_addr    = addr;
      reg_wr_data = data;
      @(posedge asclk);
      #1;
      reg_wr = 1'b0;
   endtask

   task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
      int t;
      @(posedge asclk);
      #1;
      reg_rd   = 1'b1;
      reg_addr = addr;
      @(posedge asclk);
      #1;
      reg_rd = 1'b0;
      t      = 0;
      while (!reg_rd_valid && t < TIMEOUT) begin
         @(posedge asclk);
         #1;
         t++;
      end
      data = reg_rd_data;
      if (!reg_rd_valid) begin
         report_error($sformatf("no read reply from address 0x%0h", addr));
      end
   endtask

   task automatic check_reg(input reg_addr_t addr, input reg_data_t expected,
                            input string what);
      reg_data_t val;
      reg_read(addr, val);
      if (val !== expected) begin
         report_mismatch(what, 64'(expected), 64'(val));
      end
   endtask

   task automatic check_counters();
      reg_addr_t offs;
      check_reg(REG_HIT_CNT, exp_hit, "hit count");
      check_reg(REG_MISS_CNT, exp_miss, "miss count");
      for (int p = 0; p < NUM_PORTS; p++) begin
         offs = reg_addr_t'(REG_CNT_STRIDE * p);
         check_reg(REG_FWD_CNT_BASE + offs, exp_fwd[p], $sformatf("fwd count port %0d", p));
         check_reg(REG_DROP_CNT_BASE + offs, exp_drop[p], $sformatf("drop count port %0d", p));
      end
   endtask

   task automatic program_entry(input logic [7:0] index, input match_key_t key,
                                input action_t action, input logic valid);
      reg_data_t cmd;
      cmd                = '0;
      cmd[7:0]           = index;
      cmd[CMD_VALID_BIT] = valid;
      reg_write(REG_KEY_LO, key[31:0]);
      reg_write(REG_KEY_HI, key[63:32]);
      reg_write(REG_ACTION, 32'(action));
      reg_write(REG_ENTRY_CMD, cmd);
   endtask

   // Key word first, then LFSR payload
   task automatic add_packet(input int port, input match_key_t key, input int len);
      data_word_t w;
      for (int i = 0; i < len; i++) begin
         w = key;
         if (i != 0) begin
            for (int b = 0; b < DATA_W; b++) begin
               w[b] = lfsr_step(payload_lfsr);
            end
         end
         stim_data[port].push_back(w);
         stim_last[port].push_back(i == len - 1);
      end
   endtask

   task automatic clear_stim();
      for (int p = 0; p < NUM_PORTS; p++) begin
         stim_data[p].delete();
         stim_last[p].delete();
      end
   endtask

   task automatic send_packet(input int port);
      int t;
      @(posedge asclk);
      #1;
      for (int i = 0; i < stim_data[port].size(); i++) begin
         s_tdata[port]  = stim_data[port][i];
         s_tlast[port]  = stim_last[port][i];
         s_tvalid[port] = 1'b1;
         t = 0;
         #1;
         while (!s_tready[port] && t < TIMEOUT) begin
            @(posedge asclk);
            #2;
            t++;
         end
         if (!s_tready[port]) begin
            report_error($sformatf("port %0d ingress stuck at word %0d", port, i));
            break;
         end
         @(posedge asclk);
         #1;
      end
      s_tvalid[port] = 1'b0;
      s_tlast[port]  = 1'b0;
   endtask

   // A beat seen mid-cycle with valid and ready transfers on the next edge
   task automatic collect_packet(input int port, input port_mask_t mask);
      int t;
      int i;
      t = 0;
      i = 0;
      while (i < stim_data[port].size() && t < TIMEOUT) begin
         @(posedge asclk);
         #2;
         t++;
         if (m_tvalid[port] && m_tready[port]) begin
            if (m_tdata[port] !== stim_data[port][i]) begin
               report_mismatch($sformatf("port %0d word %0d data", port, i),
                               stim_data[port][i], m_tdata[port]);
            end
            if (m_tlast[port] !== stim_last[port][i]) begin
               report_mismatch($sformatf("port %0d word %0d tlast", port, i),
                               64'(stim_last[port][i]), 64'(m_tlast[port]));
            end
            if (m_tuser[port] !== mask) begin
               report_mismatch($sformatf("port %0d word %0d tuser", port, i),
                               64'(mask), 64'(m_tuser[port]));
            end
            i++;
            t = 0;
         end
      end
      if (i < stim_data[port].size()) begin
         report_error($sformatf("port %0d egress timed out after %0d of %0d words",
                                port, i, stim_data[port].size()));
      end
   endtask

   task automatic expect_silence(input int port, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(posedge asclk);
         #2;
         if (m_tvalid[port]) begin
            report_error($sformatf("port %0d emitted a word for a dropped packet", port));
            break;
         end
      end
   endtask

   task automatic test_reset_state();
      start_test("reset_state");
      if (s_tready !== {NUM_PORTS{1'b1}}) begin
         report_mismatch("s_tready", 64'({NUM_PORTS{1'b1}}), 64'(s_tready));
      end
      if (m_tvalid !== '0) begin
         report_mismatch("m_tvalid", 64'(0), 64'(m_tvalid));
      end
      check_counters();
      finish_test();
   endtask

   task automatic test_miss_drop();
      start_test("miss_drop");
      clear_stim();
      add_packet(0, KEY_A, 4);
      fork
         send_packet(0);
         expect_silence(0, 40);
      join
      exp_miss    = exp_miss + 1;
      exp_drop[0] = exp_drop[0] + 1;
      check_counters();
      finish_test();
   endtask

   task automatic test_hit_forward();
      start_test("hit_forward");
      program_entry(8'd3, KEY_A, 16'h0002, 1'b1);
      clear_stim();
      add_packet(0, KEY_A, 5);
      fork
         send_packet(0);
         collect_packet(0, 8'h02);
      join
      exp_hit    = exp_hit + 1;
      exp_fwd[0] = exp_fwd[0] + 1;
      check_counters();
      finish_test();
   endtask

   task automatic test_drop_action();
      start_test("drop_action");
      program_entry(8'd5, KEY_B, 16'h8001, 1'b1);
      clear_stim();
      add_packet(1, KEY_B, 3);
      fork
         send_packet(1);
         expect_silence(1, 40);
      join
      exp_hit     = exp_hit + 1;
      exp_drop[1] = exp_drop[1] + 1;
      check_counters();
      finish_test();
   endtask

   task automatic test_contention();
      logic [2:0] r;
      start_test("contention");
      program_entry(8'd1, KEY_C, 16'h0001, 1'b1);
      clear_stim();
      // Three packets per port, 1 to 8 words each
      for (int k = 0; k < 6; k++) begin
         for (int b = 0; b < 3; b++) begin
            r[b] = lfsr_step(payload_lfsr);
         end
         add_packet(k % 2, (k % 2 == 0) ? KEY_A : KEY_C, 1 + int'(r));
      end
      ready_rand = 1'b1;
      fork
         send_packet(0);
         send_packet(1);
         collect_packet(0, 8'h02);
         collect_packet(1, 8'h01);
      join
      ready_rand = 1'b0;
      exp_hit    = exp_hit + 6;
      exp_fwd[0] = exp_fwd[0] + 3;
      exp_fwd[1] = exp_fwd[1] + 3;
      check_counters();
      finish_test();
   endtask

   task automatic test_entry_removal();
      start_test("entry_removal");
      program_entry(8'd3, KEY_A, 16'h0002, 1'b0);
      clear_stim();
      add_packet(0, KEY_A, 3);
      fork
         send_packet(0);
         expect_silence(0, 40);
      join
      exp_miss    = exp_miss + 1;
      exp_drop[0] = exp_drop[0] + 1;
      check_counters();
      finish_test();
   endtask

   initial begin
      asclk        = 1'b0;
      rst_n        = 1'b0;
      s_tdata      = '0;
      s_tlast      = '0;
      s_tvalid     = '0;
      reg_wr       = 1'b0;
      reg_rd       = 1'b0;
      reg_addr     = '0;
      reg_wr_data  = '0;
      ready_rand   = 1'b0;
      payload_lfsr = 16'd59;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      exp_hit      = '0;
      exp_miss     = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         exp_fwd[p]  = '0;
         exp_drop[p] = '0;
      end

      repeat (3) @(posedge asclk);
      #1;
      rst_n = 1'b1;

      test_reset_state();
      test_miss_drop();
      test_hit_forward();
      test_drop_action();
      test_contention();
      test_entry_removal();

      $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
               errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
rtl/openflow_pkg.sv
rtl/host_regs_pkg.sv
rtl/pkt_preprocessor.sv
rtl/action_processor.sv
rtl/flow_tbl_ctrl.sv
rtl/host_inf.sv
rtl/openflow_datapath.sv
verification/openflow_datapath_asserts.sv
verification/openflow_datapath_tb.sv

// File: Makefile
TOP := openflow_datapath_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^Finished with errors$$" sim.log; then echo "Simulation reported failures"; exit 1; fi
	@grep -q "^Finished with no errors$$" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
